// File: rtl/harness_pkg.sv
/*
  Shared definitions for the Wishbone test harness.
  Bus is 32 bit wide with word-granular targets; the low address bits
  below ADDR_LSB are ignored by every target.
  Windows must be a power-of-two number of words so that the low
  word-address bits index each target directly.
*/
package harness_pkg;

  // Bus widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  sel_t;

  localparam int unsigned WORD_BYTES = $bits(data_t) / 8;
  localparam int unsigned ADDR_LSB   = $clog2(WORD_BYTES);

  // ----------------------------------------------------------------------
  // Address map
  // ----------------------------------------------------------------------
  localparam addr_t       ROM_BASE   = 32'h0000_0000;
  localparam int unsigned ROM_WORDS  = 8;
  localparam addr_t       SRAM_BASE  = 32'h1000_0000;
  localparam int unsigned SRAM_WORDS = 256;
  localparam addr_t       CTRL_BASE  = 32'h2000_0000;
  localparam int unsigned CTRL_WORDS = 2;

  // Word index inside each window
  typedef logic [$clog2(ROM_WORDS)-1:0]  rom_idx_t;
  typedef logic [$clog2(SRAM_WORDS)-1:0] sram_idx_t;
  typedef logic [$clog2(CTRL_WORDS)-1:0] ctrl_idx_t;

  // Control register slots, offset 0 and offset 4
  localparam ctrl_idx_t CTRL_EXIT_IDX   = ctrl_idx_t'(0);
  localparam ctrl_idx_t CTRL_DBG_EN_IDX = ctrl_idx_t'(1);

  // Boot image, word 0 at ROM_BASE
  localparam data_t ROM_IMAGE [ROM_WORDS] = '{
    32'h0000_0297, 32'h0202_8593, 32'hf140_2573, 32'h0182_b283,
    32'h0002_8067, 32'h8000_0000, 32'h0000_0000, 32'hdead_beef
  };

  // ----------------------------------------------------------------------
  // Debug request gate
  // ----------------------------------------------------------------------
  // Rising edges after reset release during which debug_req stays blocked
  localparam int unsigned DBG_DELAY_CYCLES = 50;
  typedef logic [$clog2(DBG_DELAY_CYCLES+1)-1:0] dbg_cnt_t;

endpackage

// File: rtl/boot_rom.sv
/*
  Read-only boot memory with a Wishbone-style single-cycle response.
  Content is the fixed package image; writes are refused with err and
  leave the image untouched. One answer per strobe, one cycle later,
  so the strobe must drop in the cycle after the response.
*/
`timescale 1ns/1ns

module boot_rom (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              stb_i,
  input  logic              we_i,
  input  harness_pkg::addr_t adr_i,
  output harness_pkg::data_t dat_o,
  output logic              ack_o,
  output logic              err_o
);
  import harness_pkg::*;

  rom_idx_t rom_idx;
  logic     access;
  logic     ack_q;
  logic     err_q;
  data_t    dat_q;

  assign rom_idx = adr_i[ADDR_LSB +: $bits(rom_idx_t)];

  // Ignore a strobe that is still held while we answer
  assign access = stb_i & ~(ack_q | err_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_resp
    if (!rst_ni) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= access & ~we_i;
      err_q <= access & we_i;
    end
  end

  // Read word only
  always_ff @(posedge clk_i) begin : p_rdata
    if (access && !we_i) begin
      dat_q <= ROM_IMAGE[rom_idx];
    end
  end

  assign dat_o = dat_q;
  assign ack_o = ack_q;
  assign err_o = err_q;

endmodule

// File: rtl/main_sram.sv
/*
  Main memory, 32-bit words with byte selects.
  A write changes only the bytes whose select is set; a read returns
  the whole word. Every access is acknowledged one cycle later.
  Content is not initialised, so reading an unwritten word gives X.
*/
`timescale 1ns/1ns

module main_sram (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               stb_i,
  input  logic               we_i,
  input  harness_pkg::addr_t adr_i,
  input  harness_pkg::data_t dat_i,
  input  harness_pkg::sel_t  sel_i,
  output harness_pkg::data_t dat_o,
  output logic               ack_o
);
  import harness_pkg::*;

  data_t     mem [SRAM_WORDS];
  sram_idx_t sram_idx;
  logic      access;
  logic      ack_q;
  data_t     dat_q;

  assign sram_idx = adr_i[ADDR_LSB +: $bits(sram_idx_t)];
  assign access   = stb_i & ~ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ack
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin : p_write
    if (access && we_i) begin
      for (int b = 0; b < WORD_BYTES; b++) begin
        if (sel_i[b]) begin
          mem[sram_idx][8*b +: 8] <= dat_i[8*b +: 8];
        end
      end
    end
  end

  // Read data is held until the next read
  always_ff @(posedge clk_i) begin : p_read
    if (access && !we_i) begin
      dat_q <= mem[sram_idx];
    end
  end

  assign dat_o = dat_q;
  assign ack_o = ack_q;

endmodule

// File: rtl/ctrl_regs.sv
/*
  Control target: exit code and debug enable, plus the debug request gate.
  Offset 0 holds the exit code (drives exit_o), offset 4 holds the debug
  enable in bit 0. Both reset values are fixed: exit 0, enable 1.
  debug_req_o is blocked for DBG_DELAY_CYCLES edges after reset release,
  then follows the registered request ANDed with the enable.
*/
`timescale 1ns/1ns

module ctrl_regs (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               stb_i,
  input  logic               we_i,
  input  harness_pkg::addr_t adr_i,
  input  harness_pkg::data_t dat_i,
  output harness_pkg::data_t dat_o,
  output logic               ack_o,
  input  logic               debug_req_i,
  output logic               debug_req_o,
  output harness_pkg::data_t exit_o
);
  import harness_pkg::*;

  ctrl_idx_t reg_idx;
  logic      access;
  logic      ack_q;
  data_t     dat_q;
  data_t     exit_q;
  logic      dbg_en_q;
  dbg_cnt_t  del_cnt_q;
  logic      dbg_req_q;

  assign reg_idx = adr_i[ADDR_LSB +: $bits(ctrl_idx_t)];
  assign access  = stb_i & ~ack_q;

  // ----------------------------------------------------------------------
  // Register file
  // ----------------------------------------------------------------------
  // Registers update on the same edge that raises ack
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      ack_q    <= 1'b0;
      exit_q   <= '0;
      dbg_en_q <= 1'b1;
    end else begin
      ack_q <= access;
      if (access && we_i) begin
        if (reg_idx == CTRL_EXIT_IDX) begin
          exit_q <= dat_i;
        end
        if (reg_idx == CTRL_DBG_EN_IDX) begin
          dbg_en_q <= dat_i[0];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_rdata
    if (access && !we_i) begin
      dat_q <= (reg_idx == CTRL_EXIT_IDX) ? exit_q : data_t'(dbg_en_q);
    end
  end

  // ----------------------------------------------------------------------
  // Debug request gate
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_dbg_gate
    if (!rst_ni) begin
      del_cnt_q <= dbg_cnt_t'(DBG_DELAY_CYCLES);
      dbg_req_q <= 1'b0;
    end else begin
      if (del_cnt_q != '0) begin
        del_cnt_q <= del_cnt_q - 1'b1;
      end
      dbg_req_q <= debug_req_i & dbg_en_q;
    end
  end

  // Counter at zero opens the gate
  assign debug_req_o = dbg_req_q & (del_cnt_q == '0);

  assign dat_o  = dat_q;
  assign ack_o  = ack_q;
  assign exit_o = exit_q;

endmodule

// File: rtl/bus_fabric.sv
/*
  Address decode and response merge for the Wishbone slave port.
  Exactly one target strobe is raised for a mapped address; an address
  outside all windows is answered here with err one cycle later.
  Read data comes from the target that acks, zero otherwise, so err
  responses always carry zero data.
*/
`timescale 1ns/1ns

module bus_fabric (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Master side
  input  logic               cyc_i,
  input  logic               stb_i,
  input  harness_pkg::addr_t adr_i,
  output logic               ack_o,
  output logic               err_o,
  output harness_pkg::data_t dat_o,
  // Target strobes
  output logic               rom_stb_o,
  output logic               sram_stb_o,
  output logic               ctrl_stb_o,
  // Target returns
  input  logic               rom_ack_i,
  input  logic               rom_err_i,
  input  harness_pkg::data_t rom_dat_i,
  input  logic               sram_ack_i,
  input  harness_pkg::data_t sram_dat_i,
  input  logic               ctrl_ack_i,
  input  harness_pkg::data_t ctrl_dat_i
);
  import harness_pkg::*;

  logic req;
  logic rom_hit;
  logic sram_hit;
  logic ctrl_hit;
  logic unmapped_err_q;

  // Wrapping subtraction keeps this a single compare per window
  function automatic logic in_window(addr_t adr, addr_t base, int unsigned words);
    addr_t offset;
    offset = adr - base;
    return offset < addr_t'(words * WORD_BYTES);
  endfunction

  // ----------------------------------------------------------------------
  // Decode
  // ----------------------------------------------------------------------
  assign req      = cyc_i & stb_i;
  assign rom_hit  = in_window(adr_i, ROM_BASE, ROM_WORDS);
  assign sram_hit = in_window(adr_i, SRAM_BASE, SRAM_WORDS);
  assign ctrl_hit = in_window(adr_i, CTRL_BASE, CTRL_WORDS);

  assign rom_stb_o  = req & rom_hit;
  assign sram_stb_o = req & sram_hit;
  assign ctrl_stb_o = req & ctrl_hit;

  // Error responder for unmapped addresses, same one-shot rule as targets
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_unmapped
    if (!rst_ni) begin
      unmapped_err_q <= 1'b0;
    end else begin
      unmapped_err_q <= req & ~(rom_hit | sram_hit | ctrl_hit) & ~unmapped_err_q;
    end
  end

  // ----------------------------------------------------------------------
  // Response merge
  // ----------------------------------------------------------------------
  assign ack_o = rom_ack_i | sram_ack_i | ctrl_ack_i;
  assign err_o = rom_err_i | unmapped_err_q;

  always_comb begin
    if (rom_ack_i) begin
      dat_o = rom_dat_i;
    end else if (sram_ack_i) begin
      dat_o = sram_dat_i;
    end else if (ctrl_ack_i) begin
      dat_o = ctrl_dat_i;
    end else begin
      dat_o = '0;
    end
  end

endmodule

// File: rtl/harness_top.sv
/*
  Harness top: Wishbone classic slave port in front of boot ROM, main SRAM
  and the control registers. One transaction in flight at a time; the
  master holds its request until ack or err and drops stb the cycle after.
  exit_o carries the exit code, debug_req_o the gated debug request.
*/
`timescale 1ns/1ns

module harness_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Wishbone slave port
  input  logic               cyc_i,
  input  logic               stb_i,
  input  logic               we_i,
  input  harness_pkg::addr_t adr_i,
  input  harness_pkg::data_t dat_i,
  input  harness_pkg::sel_t  sel_i,
  output harness_pkg::data_t dat_o,
  output logic               ack_o,
  output logic               err_o,
  // Debug and exit
  input  logic               debug_req_i,
  output logic               debug_req_o,
  output harness_pkg::data_t exit_o
);
  import harness_pkg::*;

  logic  rom_stb;
  logic  rom_ack;
  logic  rom_err;
  data_t rom_dat;
  logic  sram_stb;
  logic  sram_ack;
  data_t sram_dat;
  logic  ctrl_stb;
  logic  ctrl_ack;
  data_t ctrl_dat;

  // ----------------------------------------------------------------------
  // Fabric
  // ----------------------------------------------------------------------
  bus_fabric i_bus_fabric (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .cyc_i      ( cyc_i    ),
    .stb_i      ( stb_i    ),
    .adr_i      ( adr_i    ),
    .ack_o      ( ack_o    ),
    .err_o      ( err_o    ),
    .dat_o      ( dat_o    ),
    .rom_stb_o  ( rom_stb  ),
    .sram_stb_o ( sram_stb ),
    .ctrl_stb_o ( ctrl_stb ),
    .rom_ack_i  ( rom_ack  ),
    .rom_err_i  ( rom_err  ),
    .rom_dat_i  ( rom_dat  ),
    .sram_ack_i ( sram_ack ),
    .sram_dat_i ( sram_dat ),
    .ctrl_ack_i ( ctrl_ack ),
    .ctrl_dat_i ( ctrl_dat )
  );

  // ----------------------------------------------------------------------
  // Targets
  // ----------------------------------------------------------------------
  boot_rom i_boot_rom (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .stb_i  ( rom_stb ),
    .we_i   ( we_i    ),
    .adr_i  ( adr_i   ),
    .dat_o  ( rom_dat ),
    .ack_o  ( rom_ack ),
    .err_o  ( rom_err )
  );

  main_sram i_main_sram (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .stb_i  ( sram_stb ),
    .we_i   ( we_i     ),
    .adr_i  ( adr_i    ),
    .dat_i  ( dat_i    ),
    .sel_i  ( sel_i    ),
    .dat_o  ( sram_dat ),
    .ack_o  ( sram_ack )
  );

  ctrl_regs i_ctrl_regs (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .stb_i       ( ctrl_stb    ),
    .we_i        ( we_i        ),
    .adr_i       ( adr_i       ),
    .dat_i       ( dat_i       ),
    .dat_o       ( ctrl_dat    ),
    .ack_o       ( ctrl_ack    ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o ),
    .exit_o      ( exit_o      )
  );

endmodule

// File: tests/harness_chk.sv
/*
  Protocol assertions on the harness Wishbone port, bound to harness_top.
  Only active while rst_ni is high. Expects single-cycle responses,
  no bursts and one transaction in flight.
*/
`timescale 1ns/1ns

module harness_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i,
  input logic err_i
);

  logic resp;

  assign resp = ack_i | err_i;

  // ack and err are exclusive
  a_resp_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ack_i && err_i))
    else $error("ack_o and err_o high in the same cycle");

  // Response needs a request in the cycle before
  a_resp_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp |-> $past(cyc_i && stb_i))
    else $error("response without a request in the previous cycle");

  // One cycle only
  a_resp_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp |=> !resp)
    else $error("response held for more than one cycle");

endmodule

bind harness_top harness_chk i_harness_chk (
  .clk_i  ( clk_i  ),
  .rst_ni ( rst_ni ),
  .cyc_i  ( cyc_i  ),
  .stb_i  ( stb_i  ),
  .ack_i  ( ack_o  ),
  .err_i  ( err_o  )
);

// File: tests/tb_harness.sv
/*
  Testbench for the Wishbone harness, driven as bus master.
  Transactions and expected responses come from tests/harness_testdata.hex,
  opened relative to the project root, so the simulation starts there.
  debug_req_i is held high from reset for the debug gate checks.
  One transaction at a time, stb dropped the cycle after the response.
*/
`timescale 1ns/1ns

module tb_harness;
  import harness_pkg::*;

  localparam int unsigned MAX_LINES = 64;
  localparam int unsigned FIELDS    = 6;
  localparam logic [31:0] END_MARK  = 32'hffff_ffff;

  logic  clk;
  logic  rst_n;
  logic  cyc;
  logic  stb;
  logic  we;
  addr_t adr;
  data_t wdat;
  sel_t  sel;
  data_t rdat;
  logic  ack;
  logic  err;
  logic  dbg_req_in;
  logic  dbg_req_out;
  data_t exit_code;

  logic [31:0] td [MAX_LINES*FIELDS];
  data_t       sram_shadow [SRAM_WORDS];
  logic        dbg_en_model;
  logic [31:0] lfsr;
  int unsigned n_lines;
  int unsigned limit;
  int unsigned errors;
  int unsigned test_errors;
  int unsigned tests_run;
  int unsigned tests_failed;

  harness_top DUT (
    .clk_i       ( clk         ),
    .rst_ni      ( rst_n       ),
    .cyc_i       ( cyc         ),
    .stb_i       ( stb         ),
    .we_i        ( we          ),
    .adr_i       ( adr         ),
    .dat_i       ( wdat        ),
    .sel_i       ( sel         ),
    .dat_o       ( rdat        ),
    .ack_o       ( ack         ),
    .err_o       ( err         ),
    .debug_req_i ( dbg_req_in  ),
    .debug_req_o ( dbg_req_out ),
    .exit_o      ( exit_code   )
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------
  // Galois form with taps for x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
  endfunction

  function automatic string group_name(int unsigned t);
    case (t)
      0:       return "debug request delay window";
      1:       return "boot ROM read and write";
      2:       return "SRAM byte selects";
      3:       return "unmapped addresses";
      4:       return "exit code register";
      5:       return "debug enable register";
      default: return "unknown group";
    endcase
  endfunction

  task automatic check(string name, logic [31:0] exp, logic [31:0] act);
    if (act !== exp) begin
      $display("ERROR %0t ns %s expected %h actual %h", $time, name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic close_group(int unsigned t);
    tests_run++;
    if (test_errors == 0) begin
      $display("[%0d] %s: ok", t, group_name(t));
    end else begin
      tests_failed++;
      $display("[%0d] %s: %0d mismatches", t, group_name(t), test_errors);
    end
    test_errors = 0;
  endtask

  // Random idle of 0 to 3 cycles from two LFSR bits
  task automatic idle_gap();
    int unsigned gap;
    gap = 0;
    repeat (2) begin
      lfsr = lfsr_next(lfsr);
      gap  = gap * 2 + 32'(lfsr[0]);
    end
    repeat (gap) @(posedge clk);
  endtask

  // Drive one data file line, wait for the response and check it
  task automatic run_line(int unsigned i);
    logic [31:0] op;
    addr_t       a;
    data_t       wd;
    sel_t        s;
    data_t       exp_dat;
    logic        exp_err;
    int unsigned idx;
    op      = td[i*FIELDS];
    a       = td[i*FIELDS+1];
    wd      = td[i*FIELDS+2];
    s       = sel_t'(td[i*FIELDS+3]);
    exp_dat = td[i*FIELDS+4];
    exp_err = td[i*FIELDS+5][0];
    @(posedge clk);
    cyc  <= 1'b1;
    stb  <= 1'b1;
    we   <= op[0];
    adr  <= a;
    wdat <= wd;
    sel  <= s;
    @(negedge clk);
    while (!(ack || err)) @(negedge clk);
    check("ack_o", {31'b0, !exp_err}, {31'b0, ack});
    check("err_o", {31'b0, exp_err}, {31'b0, err});
    if (!op[0] || exp_err) begin
      check("dat_o", exp_dat, rdat);
    end
    // Byte-merge model of the SRAM word
    if (op[7:4] == 4'd2) begin
      idx = (a - SRAM_BASE) / WORD_BYTES;
      if (op[0]) begin
        for (int b = 0; b < 4; b++) begin
          if (s[b]) begin
            sram_shadow[idx][8*b +: 8] = wd[8*b +: 8];
          end
        end
      end else begin
        check("dat_o (merged bytes)", sram_shadow[idx], rdat);
      end
    end
    if (op[7:4] == 4'd4 && op[0]) begin
      check("exit_o", wd, exit_code);
    end
    // Old enable still visible in the ack cycle
    if (op[7:4] == 4'd5 && op[0]) begin
      check("debug_req_o", {31'b0, dbg_en_model}, {31'b0, dbg_req_out});
      dbg_en_model = wd[0];
    end
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
    // Gate follows the new enable one cycle after the ack
    if (op[7:4] == 4'd5 && op[0]) begin
      @(negedge clk);
      check("debug_req_o", {31'b0, dbg_en_model}, {31'b0, dbg_req_out});
    end
  endtask

  // --------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------
  initial begin : main
    int unsigned t_cur;
    int unsigned t_line;
    rst_n        = 1'b0;
    cyc          = 1'b0;
    stb          = 1'b0;
    we           = 1'b0;
    adr          = '0;
    wdat         = '0;
    sel          = '0;
    dbg_req_in   = 1'b1;
    dbg_en_model = 1'b1;
    lfsr         = 32'h43bf_cc44;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int unsigned i = 0; i < MAX_LINES*FIELDS; i++) begin
      td[i] = END_MARK;
    end
    $readmemh("tests/harness_testdata.hex", td);
    n_lines = 0;
    while (n_lines < MAX_LINES && td[n_lines*FIELDS] != END_MARK) n_lines++;
    if (n_lines == 0) begin
      $display("Data file tests/harness_testdata.hex holds no transactions");
      errors++;
    end
    limit = n_lines * 8 + DBG_DELAY_CYCLES + 100;

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // Blocked until edge DBG_DELAY_CYCLES after reset release
    for (int unsigned k = 1; k <= DBG_DELAY_CYCLES + 2; k++) begin
      @(posedge clk);
      @(negedge clk);
      check("debug_req_o", {31'b0, k >= DBG_DELAY_CYCLES}, {31'b0, dbg_req_out});
    end
    close_group(0);

    t_cur = 0;
    for (int unsigned i = 0; i < n_lines; i++) begin
      t_line = 32'(td[i*FIELDS][7:4]);
      if (t_line != t_cur) begin
        if (t_cur != 0) begin
          close_group(t_cur);
        end
        t_cur = t_line;
        if (t_cur == 4) begin
          check("exit_o", '0, exit_code);
        end
      end
      run_line(i);
      idle_gap();
    end
    if (t_cur != 0) begin
      close_group(t_cur);
    end

    $display("%0d groups run, %0d with mismatches, %0d mismatches in total",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Cycle limit from the data file length
  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    wait (limit != 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: no end of run after %0d cycles", limit);
    $display("test failed");
    $finish;
  end

endmodule

// File: tests/harness_testdata.hex
// op (group*16 + 1 write / 0 read), address, write data, selects,
// expected read data (0 for acked writes), response (0 ack, 1 err)
10 00000000 00000000 f 00000297 0
10 00000004 00000000 f 02028593 0
10 00000008 00000000 f f1402573 0
10 0000000c 00000000 f 0182b283 0
10 00000010 00000000 f 00028067 0
10 00000014 00000000 f 80000000 0
10 00000018 00000000 f 00000000 0
10 0000001c 00000000 f deadbeef 0
11 00000008 12345678 f 00000000 1
10 00000008 00000000 f f1402573 0
21 10000010 a1b2c3d4 f 00000000 0
21 10000010 55667788 5 00000000 0
20 10000010 00000000 f a166c388 0
21 100003fc 01020304 f 00000000 0
21 100003fc ffeeddcc a 00000000 0
20 100003fc 00000000 f ff02dd04 0
30 30000000 00000000 f 00000000 1
31 30000000 cafef00d f 00000000 1
30 00000020 00000000 f 00000000 1
31 20000008 11111111 f 00000000 1
40 20000000 00000000 f 00000000 0
41 20000000 0000002a f 00000000 0
40 20000000 00000000 f 0000002a 0
50 20000004 00000000 f 00000001 0
51 20000004 00000000 f 00000000 0
50 20000004 00000000 f 00000000 0
51 20000004 00000001 f 00000000 0
50 20000004 00000000 f 00000001 0

// File: tb.f
rtl/harness_pkg.sv
rtl/boot_rom.sv
rtl/main_sram.sv
rtl/ctrl_regs.sv
rtl/bus_fabric.sv
rtl/harness_top.sv
tests/harness_chk.sv
tests/tb_harness.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_harness
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := test failed
PASS_MSG  := test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
